// File: project.f
design/board_timing_pkg.sv
design/board_cfg_pkg.sv
design/board_cfg_if.sv
design/machine_config.sv
design/clock_enable_gen.sv
design/reset_sequencer.sv
design/splash_timer.sv
design/pcxt_board_ctrl.sv
bench/tb_clock_gen.sv
bench/tb_checker.sv
bench/pcxt_board_ctrl_asserts.sv
bench/tb_pcxt_board_ctrl.sv

// File: bench/board_vectors.txt
# name kind status_hex button port_b_sel cycles expected_hex
# kind 1 power-on, 2 restart, 3 soft reset, 4 rates, 5 turbo, 6 decode, 7 model hold
power_on_splash 1 00000000 0 0 0 0
restart_skip 2 00000080 0 0 0 0
decode_ar0_cga_lo 6 00000080 0 0 0 002000CD
decode_ar1_mda_hi 6 00000192 0 1 0 00000003
decode_ar2_cga_hi 6 00000284 0 1 0 00080012
decode_ar3_mda_lo 6 00000396 0 0 0 0010002D
rate_slow 4 00000080 0 0 100000 0
rate_mid 4 00020080 0 0 100000 1
rate_fast 4 00040080 0 0 100000 1
rate_code3 4 00060080 0 0 100000 0
turbo_to_mid 5 00020080 0 0 30 1
turbo_to_slow 5 00000080 0 0 30 0
tandy_hold 7 00000088 0 0 0 0
soft_button 3 00000088 1 0 0 1
tandy_hold_set 7 00000080 0 0 0 1
soft_status 3 00000081 0 0 0 0

// File: bench/tb_pcxt_board_ctrl.sv
// Testbench top, reads the vector file, drives the DUT on the falling edge and runs each test
`timescale 1ns/1ps

module tb_pcxt_board_ctrl import board_timing_pkg::*, board_cfg_pkg::*; ();

	logic CLK_50M, reset_wire, restart;
	logic [31:0] status;
	logic user_button, port_b_sel, rand_en;
	logic bus_cycle_done = 1'b0;
	int bus_pulses = 0;
	logic sys_reset, cpu_reset, splash_active, cen_audio, cen_cpu, cen_peripheral;
	logic turbo_mode, tandy_mode, mda_mode;
	logic [3:0] port_c_sw;
	logic [12:0] video_arx, video_ary;
	logic [1:0] vga_sl;

	tb_clock_gen clk0 (.restart(restart), .CLK_50M(CLK_50M), .reset_wire(reset_wire));

	pcxt_board_ctrl dut0 (.*);

	tb_checker chk0 (.CLK_50M(CLK_50M), .cen_audio(cen_audio), .cen_cpu(cen_cpu),
		.cen_peripheral(cen_peripheral));

	// Bus cycle ends on random cycles while enabled
	always @(negedge CLK_50M) begin
		if (rand_en && ($urandom % 4 == 0)) begin
			bus_cycle_done <= 1'b1;
			bus_pulses     <= bus_pulses + 1;
		end else begin
			bus_cycle_done <= 1'b0;
		end
	end

	function automatic logic sig_value(input int sel);
		case (sel)
			0:       return sys_reset;
			1:       return cpu_reset;
			2:       return splash_active;
			3:       return reset_wire;
			default: return turbo_mode;
		endcase
	endfunction

	////////////////////////////////
	// Wait helpers
	////////////////////////////////
	// Cycles until a level shows up, sampled just after the falling edge
	task automatic count_until(input int sel, input logic level, input int limit,
			input string what, output int n);
		bit done;
		n = 0;
		done = 0;
		while (!done) begin
			@(negedge CLK_50M);
			#1;
			n++;
			if (sig_value(sel) == level) begin
				done = 1;
			end else if (n >= limit) begin
				chk0.note_failure({"timeout waiting for ", what});
				done = 1;
			end
		end
	endtask

	task automatic wait_sys_release(input string name);
		int n;
		count_until(0, 1'b0, POR_HOLD_CYCLES * 2, {name, " system reset release"}, n);
		chk0.compare({name, "_por"}, POR_HOLD_CYCLES + 1, n);
	endtask

	task automatic wait_cpu_release(input string name);
		int n;
		count_until(1, 1'b0, CPU_HOLD_CYCLES * 2 + 10, {name, " cpu reset release"}, n);
		chk0.compare({name, "_cpu_hold"}, CPU_HOLD_CYCLES + 1, n);
	endtask

	////////////////////////////////
	// Test sequences
	////////////////////////////////
	// Reset_wire release, splash, then the two reset releases
	task automatic run_power_up(input string name, input logic [31:0] st, input bit do_restart);
		int n;
		int exp_splash;
		exp_splash = st[ST_NO_SPLASH] ? 1 : SPLASH_UNITS * SPLASH_UNIT_CYCLES;
		@(negedge CLK_50M);
		status = st;
		user_button = 1'b0;
		if (do_restart) begin
			restart = 1'b1;
			count_until(3, 1'b1, 20, {name, " reset assertion"}, n);
			restart = 1'b0;
		end
		count_until(3, 1'b0, 20, {name, " reset_wire release"}, n);
		count_until(2, 1'b0, exp_splash * 2 + 10, {name, " splash end"}, n);
		chk0.compare({name, "_splash"}, exp_splash, n);
		chk0.compare({name, "_sys_held"}, 1, sys_reset);
		wait_sys_release(name);
		wait_cpu_release(name);
	endtask

	// Press for one cycle by button or status bit 0, ends at sys_reset release
	task automatic run_soft(input string name, input logic [31:0] st, input logic btn);
		@(negedge CLK_50M);
		status = st;
		user_button = btn;
		@(negedge CLK_50M);
		status = st & ~32'h1;
		user_button = 1'b0;
		#1;
		chk0.compare({name, "_sys_soft"}, 1, sys_reset);
		chk0.compare({name, "_cpu_soft"}, 1, cpu_reset);
		wait_sys_release(name);
	endtask

	// Lets a couple of bus cycles end so the new speed is latched
	task automatic latch_speed(input string name, input logic [31:0] st);
		int start;
		int n;
		@(negedge CLK_50M);
		status = st;
		#1;
		start = bus_pulses;
		rand_en = 1'b1;
		n = 0;
		while (bus_pulses < start + 2 && n < 200) begin
			@(negedge CLK_50M);
			#1;
			n++;
		end
		rand_en = 1'b0;
		if (n >= 200) begin
			chk0.note_failure({"timeout waiting for bus cycles in ", name});
		end
		@(negedge CLK_50M);
		#1;
	endtask

	task automatic run_turbo(input string name, input logic [31:0] st, input int n_hold,
			input logic exp);
		logic prev;
		bit held;
		int n;
		@(negedge CLK_50M);
		status = st;
		prev = turbo_mode;
		held = 1;
		// No bus cycle ends, so no change
		repeat (n_hold) begin
			@(negedge CLK_50M);
			#1;
			if (turbo_mode !== prev) begin
				held = 0;
			end
		end
		chk0.compare({name, "_held"}, 1, held);
		rand_en = 1'b1;
		count_until(4, exp, 200, {name, " turbo update"}, n);
		rand_en = 1'b0;
		chk0.compare({name, "_turbo"}, exp, turbo_mode);
	endtask

	initial begin
		int fd;
		int cnt;
		int kind;
		int btn;
		int bsel;
		int n;
		logic [31:0] st;
		logic [31:0] exp;
		reg [8*200-1:0] line;
		reg [8*32-1:0] name_r;
		string name;
		status = '0;
		user_button = 1'b0;
		port_b_sel = 1'b0;
		restart = 1'b0;
		rand_en = 1'b0;
		void'($urandom(32'h8096));
		fd = $fopen("bench/board_vectors.txt", "r");
		if (fd == 0) begin
			chk0.note_failure("cannot open the vector file");
		end else begin
			while (!$feof(fd)) begin
				line = '0;
				cnt = $fgets(line, fd);
				cnt = $sscanf(line, "%s %d %h %d %d %d %h", name_r, kind, st, btn, bsel, n, exp);
				// Header and blank lines do not parse
				if (cnt == 7) begin
					name = $sformatf("%0s", name_r);
					case (kind)
						1: run_power_up(name, st, 0);
						2: run_power_up(name, st, 1);
						3: begin
							run_soft(name, st, btn[0]);
							wait_cpu_release(name);
							chk0.compare({name, "_tandy"}, exp[0], tandy_mode);
						end
						4: begin
							latch_speed(name, st);
							chk0.compare({name, "_turbo"}, exp[0], turbo_mode);
							run_soft(name, st, 1'b1);
							chk0.count_window(n);
							chk0.check_rates(name, n, st);
						end
						5: run_turbo(name, st, n, exp[0]);
						6: begin
							@(negedge CLK_50M);
							status = st;
							port_b_sel = bsel[0];
							#1;
							chk0.compare(name, exp, {video_arx, video_ary, vga_sl, port_c_sw});
							// MDA selected by its status bit
							chk0.compare({name, "_mda"}, st[ST_MDA], mda_mode);
						end
						7: begin
							@(negedge CLK_50M);
							status = st;
							repeat (2) @(negedge CLK_50M);
							#1;
							chk0.compare({name, "_tandy"}, exp[0], tandy_mode);
						end
						default: chk0.note_failure({"unknown test kind in ", name});
					endcase
				end
			end
			$fclose(fd);
		end
		chk0.report(dut0.asrt0.fail_count);
		if (chk0.value_errors + chk0.other_errors + dut0.asrt0.fail_count == 0) begin
			$display("Simulation PASSED");
		end else begin
			$display("Simulation FAILED");
		end
		$finish;
	end

endmodule

// File: bench/pcxt_board_ctrl_asserts.sv
// Concurrent assertions on reset ordering, strobe width and splash behavior, bound into the top level
`timescale 1ns/1ps

module pcxt_board_ctrl_asserts (
	input logic CLK_50M,
	input logic reset_wire,
	input logic sys_reset,
	input logic cpu_reset,
	input logic splash_active,
	input logic cen_audio,
	input logic cen_cpu,
	input logic cen_peripheral
);

	// Assertion failures so far
	int fail_count = 0;

	// CPU never runs while the board is in reset
	a_cpu_in_reset: assert property (@(posedge CLK_50M) disable iff (reset_wire)
		sys_reset |-> cpu_reset)
		else begin
			fail_count++;
			$error("cpu_reset low while sys_reset high");
		end

	// Strobes are single cycle
	a_audio_pulse: assert property (@(posedge CLK_50M) disable iff (reset_wire)
		cen_audio |=> !cen_audio)
		else begin
			fail_count++;
			$error("cen_audio high two cycles");
		end
	a_cpu_pulse: assert property (@(posedge CLK_50M) disable iff (reset_wire)
		cen_cpu |=> !cen_cpu)
		else begin
			fail_count++;
			$error("cen_cpu high two cycles");
		end
	a_periph_pulse: assert property (@(posedge CLK_50M) disable iff (reset_wire)
		cen_peripheral |=> !cen_peripheral)
		else begin
			fail_count++;
			$error("cen_peripheral high two cycles");
		end

	// Splash only comes back with reset_wire
	a_splash_once: assert property (@(posedge CLK_50M) disable iff (reset_wire)
		!$rose(splash_active))
		else begin
			fail_count++;
			$error("splash_active rose outside reset");
		end

endmodule

bind pcxt_board_ctrl pcxt_board_ctrl_asserts asrt0 (
	.CLK_50M        (CLK_50M),
	.reset_wire     (reset_wire),
	.sys_reset      (sys_reset),
	.cpu_reset      (cpu_reset),
	.splash_active  (splash_active),
	.cen_audio      (cen_audio),
	.cen_cpu        (cen_cpu),
	.cen_peripheral (cen_peripheral)
);

// File: bench/tb_checker.sv
// Testbench checker, counts strobes, compares results and prints the closing error line
`timescale 1ns/1ps

module tb_checker import board_timing_pkg::*, board_cfg_pkg::*; (
	input logic CLK_50M,
	input logic cen_audio,
	input logic cen_cpu,
	input logic cen_peripheral
);

	int value_errors = 0;
	int other_errors = 0;
	// Strobe counts of the last window
	int n_audio;
	int n_cpu;
	int n_periph;

	task automatic compare(input string name, input longint exp, input longint act);
		if (exp !== act) begin
			value_errors++;
			$display("FAIL %s expected %0d actual %0d", name, exp, act);
		end
	endtask

	task automatic note_failure(input string msg);
		other_errors++;
		$display("ERROR: %s", msg);
	endtask

	////////////////////////////////
	// Strobe windows
	////////////////////////////////
	// Sampled just after each falling edge
	task automatic count_window(input int n);
		n_audio  = 0;
		n_cpu    = 0;
		n_periph = 0;
		repeat (n) begin
			@(negedge CLK_50M);
			#1;
			n_audio  += cen_audio;
			n_cpu    += cen_cpu;
			n_periph += cen_peripheral;
		end
	endtask

	// floor(N x R / system clock)
	function automatic longint pulses_for(input int n, input longint rate);
		return (longint'(n) * rate) / longint'(SYS_CLK_HZ);
	endfunction

	task automatic check_rates(input string name, input int n, input logic [31:0] st);
		longint cpu_rate;
		// 10 fast, 01 mid, anything else slow
		case (st[ST_SPEED_LO +: 2])
			2'b10:   cpu_rate = 14_318_181;
			2'b01:   cpu_rate = 7_159_090;
			default: cpu_rate = 4_772_727;
		endcase
		compare({name, "_audio"}, pulses_for(n, 44_100), n_audio);
		compare({name, "_cpu"}, pulses_for(n, cpu_rate), n_cpu);
		compare({name, "_periph"}, pulses_for(n, 2_386_363), n_periph);
	endtask

	task automatic report(input int assert_errors);
		$display("Errors: %0d value mismatches, %0d other failures, %0d assertion failures",
			value_errors, other_errors, assert_errors);
	endtask

endmodule

// File: bench/tb_clock_gen.sv
// Testbench clock and reset source, 20 ns period, reset held for 8 cycles and re-armed by restart
`timescale 1ns/1ps

module tb_clock_gen (
	input  logic restart,
	output logic CLK_50M,
	output logic reset_wire
);

	initial begin
		CLK_50M = 1'b0;
	end

	// 50 MHz
	always #10 CLK_50M = ~CLK_50M;

	// Power-on reset, then one more reset per restart request
	initial begin
		reset_wire = 1'b1;
		forever begin
			repeat (8) @(negedge CLK_50M);
			reset_wire = 1'b0;
			@(posedge restart);
			@(negedge CLK_50M);
			reset_wire = 1'b1;
		end
	end

endmodule

// File: design/pcxt_board_ctrl.sv
// Board control top level, clock enables, reset sequencing, splash timer and status decode
`timescale 1ns/1ps

module pcxt_board_ctrl (
	input  logic        CLK_50M,
	input  logic        reset_wire,
	input  logic [31:0] status,
	input  logic        user_button,
	input  logic        bus_cycle_done,
	input  logic        port_b_sel,
	output logic        sys_reset,
	output logic        cpu_reset,
	output logic        splash_active,
	output logic        cen_audio,
	output logic        cen_cpu,
	output logic        cen_peripheral,
	output logic        turbo_mode,
	output logic        tandy_mode,
	output logic        mda_mode,
	output logic [3:0]  port_c_sw,
	output logic [12:0] video_arx,
	output logic [12:0] video_ary,
	output logic [1:0]  vga_sl
);

	// Shared configuration and reset levels
	board_cfg_if cfg_bus ();

	////////////////////////////////
	// Blocks
	////////////////////////////////
	machine_config u_machine_config (
		.CLK_50M     (CLK_50M),
		.reset_wire  (reset_wire),
		.status      (status),
		.user_button (user_button),
		.port_b_sel  (port_b_sel),
		.cfg         (cfg_bus.decoder),
		.tandy_mode  (tandy_mode),
		.mda_mode    (mda_mode),
		.port_c_sw   (port_c_sw),
		.video_arx   (video_arx),
		.video_ary   (video_ary),
		.vga_sl      (vga_sl)
	);

	splash_timer u_splash_timer (
		.CLK_50M    (CLK_50M),
		.reset_wire (reset_wire),
		.cfg        (cfg_bus.timer)
	);

	reset_sequencer u_reset_sequencer (
		.CLK_50M    (CLK_50M),
		.reset_wire (reset_wire),
		.cfg        (cfg_bus.sequencer),
		.cpu_reset  (cpu_reset)
	);

	clock_enable_gen u_clock_enable_gen (
		.CLK_50M        (CLK_50M),
		.reset_wire     (reset_wire),
		.cfg            (cfg_bus.clocks),
		.bus_cycle_done (bus_cycle_done),
		.cen_audio      (cen_audio),
		.cen_cpu        (cen_cpu),
		.cen_peripheral (cen_peripheral),
		.turbo_mode     (turbo_mode)
	);

	// Levels out to the pins
	assign sys_reset     = cfg_bus.sys_reset;
	assign splash_active = cfg_bus.splash_active;

endmodule

// File: design/splash_timer.sv
// Splash screen hold timer, keeps the board in reset until the splash ends or is skipped
`timescale 1ns/1ps

module splash_timer import board_timing_pkg::*; (
	input  logic       CLK_50M,
	input  logic       reset_wire,
	board_cfg_if.timer cfg
);

	unit_cnt_t   unit_cnt;
	// Whole splash units elapsed
	splash_cnt_t splash_cnt;

	always_ff @(posedge CLK_50M or posedge reset_wire) begin
		if (reset_wire) begin
			unit_cnt          <= '0;
			splash_cnt        <= '0;
			cfg.splash_active <= 1'b1;
		end else if (cfg.splash_active) begin
			if (cfg.splash_skip) begin
				cfg.splash_active <= 1'b0;
			end else if (unit_cnt == unit_cnt_t'(SPLASH_UNIT_CYCLES - 1)) begin
				unit_cnt <= '0;
				// Last unit ends the splash
				if (splash_cnt == splash_cnt_t'(SPLASH_UNITS - 1)) begin
					cfg.splash_active <= 1'b0;
				end else begin
					splash_cnt <= splash_cnt + 1'b1;
				end
			end else begin
				unit_cnt <= unit_cnt + 1'b1;
			end
		end
	end

endmodule

// File: design/reset_sequencer.sv
// Power-on reset sequence, holds the system in reset then releases the CPU after a short delay
`timescale 1ns/1ps

module reset_sequencer import board_timing_pkg::*, board_cfg_pkg::*; (
	input  logic           CLK_50M,
	input  logic           reset_wire,
	board_cfg_if.sequencer cfg,
	output logic           cpu_reset
);

	reset_state_t state;
	// Shared between POR and CPU hold
	hold_cnt_t    hold_cnt;

	always_ff @(posedge CLK_50M or posedge reset_wire) begin
		if (reset_wire) begin
			state         <= POR_WAIT;
			hold_cnt      <= '0;
			cfg.sys_reset <= 1'b1;
			cpu_reset     <= 1'b1;
		end else if (cfg.soft_reset) begin
			// Restart from the top in any state
			state         <= POR_WAIT;
			hold_cnt      <= '0;
			cfg.sys_reset <= 1'b1;
			cpu_reset     <= 1'b1;
		end else begin
			case (state)
				POR_WAIT: begin
					// Count only once the splash is gone
					if (cfg.splash_active) begin
						hold_cnt <= '0;
					end else if (hold_cnt == hold_cnt_t'(POR_HOLD_CYCLES)) begin
						hold_cnt      <= '0;
						cfg.sys_reset <= 1'b0;
						state         <= CPU_WAIT;
					end else begin
						hold_cnt <= hold_cnt + 1'b1;
					end
				end
				CPU_WAIT: begin
					// CPU stays in reset a little past the chipset
					if (hold_cnt == hold_cnt_t'(CPU_HOLD_CYCLES)) begin
						hold_cnt  <= '0;
						cpu_reset <= 1'b0;
						state     <= RUN;
					end else begin
						hold_cnt <= hold_cnt + 1'b1;
					end
				end
				RUN: begin
					hold_cnt <= '0;
				end
				default: begin
					state <= POR_WAIT;
				end
			endcase
		end
	end

endmodule

// File: design/clock_enable_gen.sv
// Fractional clock enable strobes for audio, CPU and peripheral bus, with the turbo flag latch
`timescale 1ns/1ps

module clock_enable_gen import board_timing_pkg::*, board_cfg_pkg::*; (
	input  logic        CLK_50M,
	input  logic        reset_wire,
	board_cfg_if.clocks cfg,
	input  logic        bus_cycle_done,
	output logic        cen_audio,
	output logic        cen_cpu,
	output logic        cen_peripheral,
	output logic        turbo_mode
);

	// Index 0 audio, 1 CPU, 2 peripheral
	acc_t [2:0]  rate;
	acc_t [2:0]  acc;
	acc_t [2:0]  acc_next;
	logic [2:0]  cen_q;
	acc_t        cpu_inc;
	cpu_speed_t  speed_q;

	////////////////////////////////
	// Speed latch
	////////////////////////////////
	// New speed only at the end of a bus cycle
	always_ff @(posedge CLK_50M or posedge reset_wire) begin
		if (reset_wire) begin
			speed_q    <= SPEED_4_77;
			turbo_mode <= 1'b0;
		end else if (bus_cycle_done) begin
			speed_q    <= cfg.cpu_speed;
			turbo_mode <= (cfg.cpu_speed != SPEED_4_77);
		end
	end

	// CPU increment from the latched speed
	always_comb begin
		case (speed_q)
			SPEED_14_32: cpu_inc = CPU_RATE_FAST_HZ;
			SPEED_7_16:  cpu_inc = CPU_RATE_MID_HZ;
			default:     cpu_inc = CPU_RATE_SLOW_HZ;
		endcase
	end

	////////////////////////////////
	// Accumulators
	////////////////////////////////
	assign rate[0] = AUDIO_RATE_HZ;
	assign rate[1] = cpu_inc;
	assign rate[2] = PERIPH_RATE_HZ;

	always_comb begin
		for (int i = 0; i < 3; i++) begin
			acc_next[i] = acc[i] + rate[i];
		end
	end

	// Wrap at the system clock rate, one strobe per wrap
	always_ff @(posedge CLK_50M or posedge reset_wire) begin
		if (reset_wire) begin
			acc   <= '0;
			cen_q <= '0;
		end else if (cfg.sys_reset) begin
			// Held at zero until the board leaves reset
			acc   <= '0;
			cen_q <= '0;
		end else begin
			for (int i = 0; i < 3; i++) begin
				if (acc_next[i] >= SYS_CLK_HZ) begin
					acc[i]   <= acc_next[i] - SYS_CLK_HZ;
					cen_q[i] <= 1'b1;
				end else begin
					acc[i]   <= acc_next[i];
					cen_q[i] <= 1'b0;
				end
			end
		end
	end

	assign cen_audio      = cen_q[0];
	assign cen_cpu        = cen_q[1];
	assign cen_peripheral = cen_q[2];

endmodule

// File: design/machine_config.sv
// Status word decoder for model, video mode, DIP switches, aspect ratio and scanlines
`timescale 1ns/1ps

module machine_config import board_cfg_pkg::*; (
	input  logic         CLK_50M,
	input  logic         reset_wire,
	input  status_word_t status,
	input  logic         user_button,
	input  logic         port_b_sel,
	board_cfg_if.decoder cfg,
	output logic         tandy_mode,
	output logic         mda_mode,
	output logic [3:0]   port_c_sw,
	output logic [12:0]  video_arx,
	output logic [12:0]  video_ary,
	output logic [1:0]   vga_sl
);

	logic [1:0]  speed_bits;
	logic [1:0]  ar;
	logic [1:0]  scale;
	dip_switch_t sw;

	// Raw fields
	assign speed_bits = status[ST_SPEED_LO +: 2];
	assign ar         = status[ST_AR_LO +: 2];
	assign scale      = status[ST_SCALE_LO +: 2];

	////////////////////////////////
	// Control decode
	////////////////////////////////
	// 10 is fast, 01 is mid, the rest fall back to 4.77
	always_comb begin
		case (speed_bits)
			2'b10:   cfg.cpu_speed = SPEED_14_32;
			2'b01:   cfg.cpu_speed = SPEED_7_16;
			default: cfg.cpu_speed = SPEED_4_77;
		endcase
	end

	assign cfg.splash_skip = status[ST_NO_SPLASH];
	// OSD reset or the user button
	assign cfg.soft_reset  = status[ST_SOFT_RESET] | user_button;

	// Model only sampled while the system is held in reset
	always_ff @(posedge CLK_50M or posedge reset_wire) begin
		if (reset_wire) begin
			tandy_mode <= 1'b0;
		end else if (cfg.sys_reset) begin
			tandy_mode <= status[ST_MODEL];
		end
	end

	////////////////////////////////
	// Video and switches
	////////////////////////////////
	assign mda_mode = status[ST_MDA];

	// Port B bit 3 picks the switch nibble
	assign sw        = mda_mode ? DIP_MDA : DIP_CGA;
	assign port_c_sw = port_b_sel ? sw[7:4] : sw[3:0];

	// Original 4:3, otherwise full screen or custom ratio
	assign video_arx = (ar == 2'd0) ? 13'd4 : {11'd0, ar - 2'd1};
	assign video_ary = (ar == 2'd0) ? 13'd3 : 13'd0;

	// CRT 50% on top bit, CRT 25% on bottom
	assign vga_sl = {scale == 2'd3, scale == 2'd2};

endmodule

// File: design/board_cfg_if.sv
// Decoded configuration and reset levels shared between the board control blocks
`timescale 1ns/1ps

interface board_cfg_if import board_cfg_pkg::*; ();

	// Decoded from the status word
	cpu_speed_t cpu_speed;
	logic       splash_skip;
	logic       soft_reset;

	// Reset and splash levels
	logic       sys_reset;
	logic       splash_active;

	modport decoder   (output cpu_speed, output splash_skip, output soft_reset, input sys_reset);

	modport sequencer (input soft_reset, input splash_active, output sys_reset);

	modport timer     (input splash_skip, output splash_active);

	modport clocks    (input cpu_speed, input sys_reset);

endinterface

// File: design/board_cfg_pkg.sv
// Status word layout, DIP switch values and configuration types shared by the board control blocks
package board_cfg_pkg;

	////////////////////////////////
	// Types
	////////////////////////////////
	typedef logic [31:0] status_word_t;
	typedef logic [7:0]  dip_switch_t;

	// CPU clock selection
	typedef enum logic [1:0] {
		SPEED_4_77  = 2'd0,
		SPEED_7_16  = 2'd1,
		SPEED_14_32 = 2'd2
	} cpu_speed_t;

	// Reset release sequence
	typedef enum logic [1:0] {
		POR_WAIT = 2'd0,
		CPU_WAIT = 2'd1,
		RUN      = 2'd2
	} reset_state_t;

	////////////////////////////////
	// Status word bit positions
	////////////////////////////////
	localparam int ST_SOFT_RESET = 0;
	// Scandoubler effect, two bits
	localparam int ST_SCALE_LO   = 1;
	// 0 is IBM PCXT, 1 is Tandy 1000
	localparam int ST_MODEL      = 3;
	localparam int ST_MDA        = 4;
	localparam int ST_NO_SPLASH  = 7;
	// Aspect ratio, two bits
	localparam int ST_AR_LO      = 8;
	// CPU speed, two bits
	localparam int ST_SPEED_LO   = 17;

	// PCXT DIP switches, MDA or CGA 80 column
	localparam dip_switch_t DIP_MDA = 8'h3D;
	localparam dip_switch_t DIP_CGA = 8'h2D;

endpackage

// File: design/board_timing_pkg.sv
// Timing constants for the board control logic, imported by the RTL and the testbench checker
package board_timing_pkg;

	////////////////////////////////
	// Rate accumulators
	////////////////////////////////
	localparam int ACC_WIDTH = 32;
	typedef logic [ACC_WIDTH-1:0] acc_t;

	// All rates in Hz against the 50 MHz system clock
	localparam acc_t SYS_CLK_HZ       = 32'd50_000_000;
	localparam acc_t AUDIO_RATE_HZ    = 32'd44_100;
	localparam acc_t CPU_RATE_SLOW_HZ = 32'd4_772_727;
	localparam acc_t CPU_RATE_MID_HZ  = 32'd7_159_090;
	localparam acc_t CPU_RATE_FAST_HZ = 32'd14_318_181;
	localparam acc_t PERIPH_RATE_HZ   = 32'd2_386_363;

	////////////////////////////////
	// Reset and splash hold times
	////////////////////////////////
	localparam int POR_HOLD_CYCLES = 65_535;
	localparam int CPU_HOLD_CYCLES = 42;
	// Shared hold counter sized for the longer of the two
	typedef logic [$clog2(POR_HOLD_CYCLES + 1)-1:0] hold_cnt_t;

	// One splash unit is 1 ms in simulation
	localparam int SPLASH_UNIT_CYCLES = 50_000;
	localparam int SPLASH_UNITS       = 5;
	typedef logic [$clog2(SPLASH_UNIT_CYCLES)-1:0] unit_cnt_t;
	typedef logic [$clog2(SPLASH_UNITS)-1:0]       splash_cnt_t;

endpackage
